//--- design/glb_pkg.sv
/* widths, vector types and the dma header layout shared by the configuration ring
   and its tiles; referenced with glb_pkg:: scoped names */
package glb_pkg;

    localparam int AXI_DATA_WIDTH      = 32;
    localparam int CFG_ADDR_WIDTH      = 12;  // byte address
    localparam int TILE_SEL_ADDR_WIDTH = 4;
    localparam int GLB_ADDR_WIDTH      = 20;
    localparam int MAX_NUM_WORDS_WIDTH = 16;
    localparam int QUEUE_DEPTH         = 4;   // dma headers per tile

    // fields of a configuration address
    localparam int CFG_REG_LSB   = 2;   // bits 1:0 must be zero
    localparam int CFG_REG_WIDTH = 5;
    localparam int CFG_TILE_LSB  = CFG_REG_LSB + CFG_REG_WIDTH;

    typedef logic [CFG_ADDR_WIDTH-1:0]      cfg_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0]      cfg_data_t;
    typedef logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;
    typedef logic [GLB_ADDR_WIDTH-1:0]      glb_addr_t;
    typedef logic [MAX_NUM_WORDS_WIDTH-1:0] num_words_t;

    // one queued store transfer
    typedef struct packed {
        logic       valid;
        glb_addr_t  start_addr;
        num_words_t num_words;
    } dma_header_t;

endpackage

//--- design/cfg_ifc.sv
/* configuration bus between ring stages; requests flow west from master to slave,
   read responses come back east */
`timescale 1ns/10ps

interface cfg_ifc;

    // requests, single-cycle strobes
    logic               wr_en;
    glb_pkg::cfg_addr_t wr_addr;
    glb_pkg::cfg_data_t wr_data;
    logic               rd_en;
    glb_pkg::cfg_addr_t rd_addr;

    // response, valid for exactly one cycle
    glb_pkg::cfg_data_t rd_data;
    logic               rd_data_valid;

    modport master (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_data_valid
    );

    modport slave (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_data_valid
    );

endinterface

//--- design/glb_cfg_ingress.sv
/* host side of the ring: registers host strobes onto the ring, drops misaligned
   requests and hands ring read responses straight back to the host */
`timescale 1ns/10ps

module glb_cfg_ingress (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en,
    input  glb_pkg::cfg_addr_t wr_addr,
    input  glb_pkg::cfg_data_t wr_data,
    input  logic               rd_en,
    input  glb_pkg::cfg_addr_t rd_addr,
    output glb_pkg::cfg_data_t rd_data,
    output logic               rd_data_valid,
    output logic               cfg_misaligned,  // sticky
    cfg_ifc.master             if_ring
);

    logic       wr_misaligned;
    logic       rd_misaligned;
    logic       misaligned_rd_q;  // local zero response pending
    logic [1:0] rd_outstanding;

    assign wr_misaligned = wr_en && (wr_addr[1:0] != 2'b00);
    assign rd_misaligned = rd_en && (rd_addr[1:0] != 2'b00);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_ring.wr_en   <= 1'b0;
            if_ring.rd_en   <= 1'b0;
            misaligned_rd_q <= 1'b0;
            cfg_misaligned  <= 1'b0;
            rd_outstanding  <= 2'd0;
        end else begin
            if_ring.wr_en   <= wr_en && !wr_misaligned;
            if_ring.rd_en   <= rd_en && !rd_misaligned;
            misaligned_rd_q <= rd_misaligned;
            if (wr_misaligned || rd_misaligned) begin
                cfg_misaligned <= 1'b1;
            end
            case ({rd_en, rd_data_valid})
                2'b10:   rd_outstanding <= rd_outstanding + 2'd1;
                2'b01:   rd_outstanding <= rd_outstanding - 2'd1;
                default: rd_outstanding <= rd_outstanding;
            endcase
        end
    end

    // address and data only matter alongside a strobe
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if_ring.wr_addr <= wr_addr;
            if_ring.wr_data <= wr_data;
        end
        if (rd_en) begin
            if_ring.rd_addr <= rd_addr;
        end
    end

    assign rd_data_valid = if_ring.rd_data_valid || misaligned_rd_q;
    assign rd_data       = misaligned_rd_q ? '0 : if_ring.rd_data;

    // host keeps a single read in flight
    a_one_read_outstanding: assert property (
        @(posedge clk) disable iff (reset) rd_en |-> (rd_outstanding == 2'd0))
        else $error("second read issued while one is outstanding");

    // every response on the ring belongs to a read issued earlier
    a_no_orphan_response: assert property (
        @(posedge clk) disable iff (reset) rd_data_valid |-> (rd_outstanding != 2'd0))
        else $error("read response without an outstanding read");

endmodule

//--- design/glb_tile_cfg.sv
/* configuration registers of one buffer tile plus its hop on the ring;
   requests for other tiles pass west, responses pass east, one cycle each */
`timescale 1ns/10ps

module glb_tile_cfg (
    input  logic                 clk,
    input  logic                 reset,
    input  glb_pkg::tile_id_t    glb_tile_id,

    cfg_ifc.slave                if_cfg_est_s,
    cfg_ifc.master               if_cfg_wst_m,

    output logic                 cfg_tile_is_start,
    output logic                 cfg_tile_is_end,
    output logic                 cfg_store_dma_on,
    output logic                 cfg_store_dma_auto_on,
    output glb_pkg::dma_header_t cfg_store_dma_header [glb_pkg::QUEUE_DEPTH]
);

    typedef logic [glb_pkg::CFG_REG_WIDTH-1:0] reg_idx_t;

    localparam reg_idx_t REG_FLAGS    = 0;  // {is_end, is_start}
    localparam reg_idx_t REG_DMA_CTRL = 1;  // {auto_on, on}
    localparam reg_idx_t REG_HDR_BASE = 2;  // two registers per header

    glb_pkg::tile_id_t  wr_tile;
    glb_pkg::tile_id_t  rd_tile;
    reg_idx_t           wr_reg;
    reg_idx_t           rd_reg;
    logic               wr_hit;
    logic               rd_hit;
    glb_pkg::cfg_data_t rd_data_int;

    assign wr_tile = if_cfg_est_s.wr_addr[glb_pkg::CFG_TILE_LSB +: glb_pkg::TILE_SEL_ADDR_WIDTH];
    assign rd_tile = if_cfg_est_s.rd_addr[glb_pkg::CFG_TILE_LSB +: glb_pkg::TILE_SEL_ADDR_WIDTH];
    assign wr_reg  = if_cfg_est_s.wr_addr[glb_pkg::CFG_REG_LSB +: glb_pkg::CFG_REG_WIDTH];
    assign rd_reg  = if_cfg_est_s.rd_addr[glb_pkg::CFG_REG_LSB +: glb_pkg::CFG_REG_WIDTH];

    assign wr_hit = if_cfg_est_s.wr_en && (wr_tile == glb_tile_id);
    assign rd_hit = if_cfg_est_s.rd_en && (rd_tile == glb_tile_id);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_tile_is_start     <= 1'b0;
            cfg_tile_is_end       <= 1'b0;
            cfg_store_dma_on      <= 1'b0;
            cfg_store_dma_auto_on <= 1'b0;
            for (int h = 0; h < glb_pkg::QUEUE_DEPTH; h++) begin
                cfg_store_dma_header[h] <= '0;
            end
        end else if (wr_hit) begin
            if (wr_reg == REG_FLAGS) begin
                {cfg_tile_is_end, cfg_tile_is_start} <= if_cfg_est_s.wr_data[1:0];
            end
            if (wr_reg == REG_DMA_CTRL) begin
                {cfg_store_dma_auto_on, cfg_store_dma_on} <= if_cfg_est_s.wr_data[1:0];
            end
            for (int h = 0; h < glb_pkg::QUEUE_DEPTH; h++) begin
                if (wr_reg == reg_idx_t'(REG_HDR_BASE + 2 * h)) begin
                    cfg_store_dma_header[h].num_words <=
                        if_cfg_est_s.wr_data[glb_pkg::MAX_NUM_WORDS_WIDTH-1:0];
                end
                if (wr_reg == reg_idx_t'(REG_HDR_BASE + 2 * h + 1)) begin
                    // valid in bit 0, start address above it
                    {cfg_store_dma_header[h].start_addr, cfg_store_dma_header[h].valid} <=
                        if_cfg_est_s.wr_data[glb_pkg::GLB_ADDR_WIDTH:0];
                end
            end
        end
    end

    // readback mux, unmapped registers give zero
    always_comb begin
        rd_data_int = '0;
        if (rd_reg == REG_FLAGS) begin
            rd_data_int = glb_pkg::cfg_data_t'({cfg_tile_is_end, cfg_tile_is_start});
        end
        if (rd_reg == REG_DMA_CTRL) begin
            rd_data_int = glb_pkg::cfg_data_t'({cfg_store_dma_auto_on, cfg_store_dma_on});
        end
        for (int h = 0; h < glb_pkg::QUEUE_DEPTH; h++) begin
            if (rd_reg == reg_idx_t'(REG_HDR_BASE + 2 * h)) begin
                rd_data_int = glb_pkg::cfg_data_t'(cfg_store_dma_header[h].num_words);
            end
            if (rd_reg == reg_idx_t'(REG_HDR_BASE + 2 * h + 1)) begin
                rd_data_int = glb_pkg::cfg_data_t'({cfg_store_dma_header[h].start_addr,
                                                    cfg_store_dma_header[h].valid});
            end
        end
    end

    // westward request stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_cfg_wst_m.wr_en <= 1'b0;
            if_cfg_wst_m.rd_en <= 1'b0;
        end else begin
            if_cfg_wst_m.wr_en <= if_cfg_est_s.wr_en && !wr_hit;
            if_cfg_wst_m.rd_en <= if_cfg_est_s.rd_en && !rd_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (if_cfg_est_s.wr_en && !wr_hit) begin
            if_cfg_wst_m.wr_addr <= if_cfg_est_s.wr_addr;
            if_cfg_wst_m.wr_data <= if_cfg_est_s.wr_data;
        end
        if (if_cfg_est_s.rd_en && !rd_hit) begin
            if_cfg_wst_m.rd_addr <= if_cfg_est_s.rd_addr;
        end
    end

    // eastward response stage, local hit wins
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_cfg_est_s.rd_data_valid <= 1'b0;
        end else begin
            if_cfg_est_s.rd_data_valid <= rd_hit || if_cfg_wst_m.rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if_cfg_est_s.rd_data <= rd_hit ? rd_data_int : if_cfg_wst_m.rd_data;
    end

    // a west response arriving with a local hit would be lost
    a_no_response_clash: assert property (
        @(posedge clk) disable iff (reset) !(rd_hit && if_cfg_wst_m.rd_data_valid))
        else $error("tile %0d: local and west read responses collide", glb_tile_id);

endmodule

//--- design/glb_cfg_terminator.sv
/* west end of the ring; anything arriving here hit no tile, so it is flagged
   and reads get a zero response */
`timescale 1ns/10ps

module glb_cfg_terminator #(
    parameter int NUM_TILES = 4
) (
    input  logic  clk,
    input  logic  reset,
    cfg_ifc.slave if_end,
    output logic  cfg_unmapped  // sticky
);

    glb_pkg::tile_id_t wr_tile;
    glb_pkg::tile_id_t rd_tile;

    assign wr_tile = if_end.wr_addr[glb_pkg::CFG_TILE_LSB +: glb_pkg::TILE_SEL_ADDR_WIDTH];
    assign rd_tile = if_end.rd_addr[glb_pkg::CFG_TILE_LSB +: glb_pkg::TILE_SEL_ADDR_WIDTH];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_end.rd_data_valid <= 1'b0;
            cfg_unmapped         <= 1'b0;
        end else begin
            if_end.rd_data_valid <= if_end.rd_en;  // answer next cycle
            if (if_end.wr_en || if_end.rd_en) begin
                cfg_unmapped <= 1'b1;
            end
        end
    end

    assign if_end.rd_data = '0;

    // only ids beyond the last tile may fall through the chain
    a_only_unmapped_ids: assert property (
        @(posedge clk) disable iff (reset)
        (if_end.wr_en |-> (int'(wr_tile) >= NUM_TILES)) and
        (if_end.rd_en |-> (int'(rd_tile) >= NUM_TILES)))
        else $error("request for a mapped tile reached the terminator");

endmodule

//--- design/glb_cfg_ring.sv
/* top level: host ingress, NUM_TILES configuration tiles chained east to west,
   and the terminator; exports the per-tile flags as vectors */
`timescale 1ns/10ps

module glb_cfg_ring #(
    parameter int NUM_TILES = 4  // 1 to 16
) (
    input  logic                 clk,
    input  logic                 reset,

    // host
    input  logic                 wr_en,
    input  glb_pkg::cfg_addr_t   wr_addr,
    input  glb_pkg::cfg_data_t   wr_data,
    input  logic                 rd_en,
    input  glb_pkg::cfg_addr_t   rd_addr,
    output glb_pkg::cfg_data_t   rd_data,
    output logic                 rd_data_valid,
    output logic                 cfg_misaligned,
    output logic                 cfg_unmapped,

    // one bit per tile
    output logic [NUM_TILES-1:0] tile_is_start,
    output logic [NUM_TILES-1:0] tile_is_end,
    output logic [NUM_TILES-1:0] store_dma_on,
    output logic [NUM_TILES-1:0] store_dma_auto_on
);

    // hop k sits east of tile k-1; hop NUM_TILES is fed by the ingress
    cfg_ifc if_hop [NUM_TILES:0] ();

    glb_cfg_ingress u_glb_cfg_ingress (
        .clk            (clk),
        .reset          (reset),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .rd_data_valid  (rd_data_valid),
        .cfg_misaligned (cfg_misaligned),
        .if_ring        (if_hop[NUM_TILES])
    );

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile_cfg u_glb_tile_cfg (
            .clk                   (clk),
            .reset                 (reset),
            .glb_tile_id           (glb_pkg::tile_id_t'(k)),
            .if_cfg_est_s          (if_hop[k+1]),
            .if_cfg_wst_m          (if_hop[k]),
            .cfg_tile_is_start     (tile_is_start[k]),
            .cfg_tile_is_end       (tile_is_end[k]),
            .cfg_store_dma_on      (store_dma_on[k]),
            .cfg_store_dma_auto_on (store_dma_auto_on[k]),
            .cfg_store_dma_header  ()  // for the store dma, outside this block
        );
    end

    glb_cfg_terminator #(
        .NUM_TILES (NUM_TILES)
    ) u_glb_cfg_terminator (
        .clk          (clk),
        .reset        (reset),
        .if_end       (if_hop[0]),
        .cfg_unmapped (cfg_unmapped)
    );

endmodule

//--- test/tb_glb_cfg_ring.sv
/* testbench for the configuration ring: drives host writes and reads, predicts
   readback from a register model and checks data, flag vectors and sticky errors */
`timescale 1ns/10ps

module tb_glb_cfg_ring;

    localparam int NUM_TILES = 4;
    localparam int NUM_REGS  = 2 + 2 * glb_pkg::QUEUE_DEPTH;
    localparam int NUM_OPS   = 110 * NUM_TILES + 2 * (16 - NUM_TILES) + 2;
    localparam int TIMEOUT_CYCLES = 50 * NUM_OPS;
    localparam glb_pkg::cfg_data_t WORDS_MASK = (32'h1 << glb_pkg::MAX_NUM_WORDS_WIDTH) - 1;
    localparam glb_pkg::cfg_data_t HDR_MASK = (32'h1 << (glb_pkg::GLB_ADDR_WIDTH + 1)) - 1;

    logic clk = 1'b0;
    logic reset;
    logic wr_en;
    logic rd_en;
    logic rd_data_valid;
    logic cfg_misaligned;
    logic cfg_unmapped;
    glb_pkg::cfg_addr_t wr_addr;
    glb_pkg::cfg_addr_t rd_addr;
    glb_pkg::cfg_data_t wr_data;
    glb_pkg::cfg_data_t rd_data;
    logic [NUM_TILES-1:0] tile_is_start;
    logic [NUM_TILES-1:0] tile_is_end;
    logic [NUM_TILES-1:0] store_dma_on;
    logic [NUM_TILES-1:0] store_dma_auto_on;

    glb_pkg::cfg_data_t model [NUM_TILES][NUM_REGS];  // expected register contents
    glb_pkg::cfg_data_t exp_q [$];
    string              name_q [$];
    logic [31:0]        rng_state = 32'h3f53_d33c;
    int reads_issued = 0;
    int reads_done = 0;
    int mismatch_count = 0;
    int other_errors = 0;
    int cycle_count = 0;

    glb_cfg_ring #(.NUM_TILES(NUM_TILES)) u_glb_cfg_ring (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // tile in bits 10:7, register in bits 6:2
    function automatic glb_pkg::cfg_addr_t make_addr(input int tile, input int reg_idx);
        return glb_pkg::cfg_addr_t'((tile << 7) | (reg_idx << 2));
    endfunction

    // stored value of a register after a write of data
    function automatic glb_pkg::cfg_data_t field_value(input int reg_idx,
                                                       input glb_pkg::cfg_data_t data);
        if (reg_idx < 2) return data & 32'h3;  // flag pairs
        if (reg_idx % 2 == 0) return data & WORDS_MASK;  // num_words
        return data & HDR_MASK;  // start_addr over valid
    endfunction

    function automatic void model_write(input glb_pkg::cfg_addr_t addr,
                                        input glb_pkg::cfg_data_t data);
        int tile;
        int reg_idx;
        tile = int'(addr[10:7]);
        reg_idx = int'(addr[6:2]);
        if (addr[1:0] == 2'b00 && tile < NUM_TILES && reg_idx < NUM_REGS)
            model[tile][reg_idx] = field_value(reg_idx, data);
    endfunction

    function automatic glb_pkg::cfg_data_t predicted_read(input glb_pkg::cfg_addr_t addr);
        int tile;
        int reg_idx;
        tile = int'(addr[10:7]);
        reg_idx = int'(addr[6:2]);
        if (addr[1:0] != 2'b00 || tile >= NUM_TILES || reg_idx >= NUM_REGS) return '0;
        return model[tile][reg_idx];
    endfunction

    function automatic logic [NUM_TILES-1:0] flag_vector(input int reg_idx, input int bit_idx);
        logic [NUM_TILES-1:0] v;
        for (int t = 0; t < NUM_TILES; t++) v[t] = model[t][reg_idx][bit_idx];
        return v;
    endfunction

    task automatic check_value(input string test_name, input glb_pkg::cfg_data_t expected,
                               input glb_pkg::cfg_data_t actual);
        assert (actual === expected) else begin
            $display("Mismatch %s: expected %h, actual %h", test_name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic compare_flags(input string test_name);
        check_value({test_name, " is_start"}, flag_vector(0, 0), tile_is_start);
        check_value({test_name, " is_end"}, flag_vector(0, 1), tile_is_end);
        check_value({test_name, " dma_on"}, flag_vector(1, 0), store_dma_on);
        check_value({test_name, " dma_auto_on"}, flag_vector(1, 1), store_dma_auto_on);
    endtask

    // posted write, then time for the request to pass every tile
    task automatic write_reg(input glb_pkg::cfg_addr_t addr, input glb_pkg::cfg_data_t data);
        model_write(addr, data);
        wr_en = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        repeat (NUM_TILES + 1) @(posedge clk);
        #1;
    endtask

    task automatic read_reg(input string test_name, input glb_pkg::cfg_addr_t addr);
        exp_q.push_back(predicted_read(addr));
        name_q.push_back(test_name);
        reads_issued++;
        rd_en = 1'b1;
        rd_addr = addr;
        @(posedge clk);
        #1;
        rd_en = 1'b0;
        while (reads_done < reads_issued) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic readback_all(input string test_name);
        for (int t = 0; t < NUM_TILES; t++)
            for (int r = 0; r < NUM_REGS; r++) read_reg(test_name, make_addr(t, r));
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_errors);
    endtask

    // response data is stable around the falling edge
    always @(negedge clk) begin : response_check
        glb_pkg::cfg_data_t expected;
        string test_name;
        if (!reset && rd_data_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("a read response arrived while no read was pending");
                other_errors++;
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                test_name = name_q.pop_front();
                check_value(test_name, expected, rd_data);
                reads_done++;
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("the run hung and was stopped after %0d cycles", cycle_count);
        report_counts();
        $display("Something failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        wr_en = 1'b0;
        rd_en = 1'b0;
        wr_addr = '0;
        rd_addr = '0;
        wr_data = '0;
        for (int t = 0; t < NUM_TILES; t++)
            for (int r = 0; r < NUM_REGS; r++) model[t][r] = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // values after reset
        readback_all("reset_readback");
        compare_flags("reset_flags");
        check_value("reset_unmapped", 0, cfg_unmapped);
        check_value("reset_misaligned", 0, cfg_misaligned);

        // random data, upper bits masked by field width
        for (int t = 0; t < NUM_TILES; t++)
            for (int r = 0; r < NUM_REGS; r++) write_reg(make_addr(t, r), next_random());
        readback_all("random_readback");
        compare_flags("random_flags");  // start and end bits differ here

        // each tile drives its own bit of the flag vectors
        for (int t = 0; t < NUM_TILES; t++) begin
            write_reg(make_addr(t, 0), 0);
            write_reg(make_addr(t, 1), 0);
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            write_reg(make_addr(t, 0), next_random() | 32'h3);
            write_reg(make_addr(t, 1), next_random() | 32'h3);
            compare_flags("flag_set");
            write_reg(make_addr(t, 0), 0);
            write_reg(make_addr(t, 1), 0);
            compare_flags("flag_clear");
        end

        // tile ids past the last tile
        check_value("unmapped_before", 0, cfg_unmapped);
        for (int t = NUM_TILES; t < 16; t++) begin
            write_reg(make_addr(t, int'(next_random() % NUM_REGS)), next_random());
            if (t == NUM_TILES) begin
                check_value("unmapped_write", 1, cfg_unmapped);  // write alone sets it
            end
            read_reg("unmapped_read", make_addr(t, int'(next_random() % NUM_REGS)));
        end
        check_value("unmapped_after", 1, cfg_unmapped);
        readback_all("unmapped_readback");

        // low address bits set
        check_value("misaligned_before", 0, cfg_misaligned);
        read_reg("misaligned_read", make_addr(0, 2) | 12'h1);
        write_reg(make_addr(0, 3) | 12'h2, next_random());
        check_value("misaligned_after", 1, cfg_misaligned);
        readback_all("misaligned_readback");

        // registers 10 to 31 hold nothing
        for (int t = 0; t < NUM_TILES; t++)
            for (int r = NUM_REGS; r < 32; r++) begin
                write_reg(make_addr(t, r), next_random());
                read_reg("reserved_read", make_addr(t, r));
            end
        readback_all("reserved_readback");
        compare_flags("final_flags");

        repeat (2) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%0d read responses never arrived", exp_q.size());
            other_errors++;
        end
        report_counts();
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- build.f
design/glb_pkg.sv
design/cfg_ifc.sv
design/glb_cfg_ingress.sv
design/glb_tile_cfg.sv
design/glb_cfg_terminator.sv
design/glb_cfg_ring.sv
test/tb_glb_cfg_ring.sv
